// File: rtl/noc_consts.svh
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// bus widths
`define NOC_DESC_W 32
`define NOC_FLIT_W 36

// virtual channels and credit depth per channel
`define NOC_NVCS 2
`define NOC_CREDITS 4
`define NOC_CREDIT_W 3

// descriptor field positions, bit 31 reserved
`define NOC_P_MEASURE 30
`define NOC_P_INJ 29:20
`define NOC_P_VC 19
`define NOC_P_SIZE 18:16
`define NOC_P_DEST 15:8
`define NOC_P_SRC 7:0

`endif

// File: rtl/noc_pkg.sv
package noc_pkg;

    // decoded packet descriptor
    typedef struct packed {
        logic       measure;
        logic [9:0] inj_time;
        logic       vc;
        logic [2:0] log_size;
        logic [7:0] dest;
        logic [7:0] src;
    } desc_t;

    // first flit of a packet
    typedef struct packed {
        logic [9:0] inj_time;
        logic [7:0] dest;
        logic [7:0] src;
        logic [3:0] flit_count;
        logic [1:0] pad;
    } flit_head_t;

    // every flit after the head
    typedef struct packed {
        logic [7:0] src;
        logic [7:0] dest;
        logic [7:0] seq;
        logic [7:0] pad;
    } flit_body_t;

    // same 32 bits, decoded by the head bit of the flit
    typedef union packed {
        flit_head_t head;
        flit_body_t body;
    } flit_payload_u;

    typedef struct packed {
        logic          head;
        logic          tail;
        logic          vc;
        logic          measure;
        flit_payload_u payload;
    } flit_t;

endpackage

// File: rtl/packet_if.sv
`timescale 1ns/10ps

// one decoded descriptor, decoder to flit generator
interface packet_if;

    logic           valid;
    logic           ready;
    noc_pkg::desc_t desc;

    modport source (
        output valid,
        output desc,
        input  ready
    );

    modport sink (
        input  valid,
        input  desc,
        output ready
    );

endinterface

// File: rtl/descriptor_decoder.sv
`timescale 1ns/10ps
`include "noc_consts.svh"

module descriptor_decoder #(
    parameter logic [7:0] node_addr = 8'h1B
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enable,
    input  logic [`NOC_DESC_W-1:0] packet_in,
    input  logic                   packet_in_valid,
    output logic                   packet_request,
    output logic                   error,
    output logic                   busy,
    packet_if.source               desc
);

    noc_pkg::desc_t decoded;
    logic           take;
    logic           src_ok;
    logic           full;
    logic           full_next;

    always_comb
    begin
        decoded.measure  = packet_in[`NOC_P_MEASURE];
        decoded.inj_time = packet_in[`NOC_P_INJ];
        decoded.vc       = packet_in[`NOC_P_VC];
        decoded.log_size = packet_in[`NOC_P_SIZE];
        decoded.dest     = packet_in[`NOC_P_DEST];
        decoded.src      = packet_in[`NOC_P_SRC];
    end

    assign take   = packet_in_valid && packet_request && enable;
    assign src_ok = decoded.src == node_addr;

    // request is only high while empty, so load and hand-off never collide
    always_comb
    begin
        full_next = full;
        if (desc.valid && desc.ready)
            full_next = 1'b0;
        if (take && src_ok)
            full_next = 1'b1;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            full           <= 1'b0;
            packet_request <= 1'b0;
            error          <= 1'b0;
        end
        else
        begin
            full           <= full_next;
            packet_request <= !full_next;
            // foreign source, dropped and flagged for good
            if (take && !src_ok)
                error <= 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (take && src_ok)
            desc.desc <= decoded;
    end

    assign desc.valid = full;
    assign busy       = full;

    // held descriptor stays put until the generator takes it
    valid_held: assert property (@(posedge clock) disable iff (reset)
        desc.valid && !desc.ready |=> desc.valid && $stable(desc.desc));

endmodule

// File: rtl/flit_generator.sv
`timescale 1ns/10ps
`include "noc_consts.svh"

module flit_generator (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 enable,
    input  logic [9:0]           sim_time,
    packet_if.sink               desc,
    input  logic [`NOC_NVCS-1:0] credit_in,
    output noc_pkg::flit_t       flit,
    output logic                 flit_valid,
    output logic                 busy
);

    noc_pkg::desc_t           pkt;
    logic                     active;
    logic [3:0]               idx;
    logic [3:0]               flit_count;
    logic                     last;
    logic                     due;
    logic                     take;
    logic [`NOC_NVCS-1:0]     spend;
    logic [`NOC_CREDIT_W-1:0] credits [`NOC_NVCS];

    // sizes above 8 flits are not supported
    assign flit_count = 4'd1 << pkt.log_size[1:0];
    assign last       = idx == flit_count - 4'd1;

    // only the head waits for its injection time
    assign due = idx != 4'd0 || sim_time >= pkt.inj_time;

    assign flit_valid = active && enable && due && credits[pkt.vc] != '0;
    assign spend      = flit_valid ? (`NOC_NVCS'(1) << pkt.vc) : '0;

    // accept the next packet alongside the tail, no bubble
    assign desc.ready = !active || (flit_valid && last);
    assign take       = desc.valid && desc.ready;
    assign busy       = active;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            active <= 1'b0;
            idx    <= 4'd0;
        end
        else if (take)
        begin
            active <= 1'b1;
            idx    <= 4'd0;
        end
        else if (flit_valid)
        begin
            if (last)
                active <= 1'b0;
            idx <= idx + 4'd1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (take)
            pkt <= desc.desc;
    end

    always_ff @(posedge clock)
    begin
        for (int v = 0; v < `NOC_NVCS; v++)
        begin
            if (reset)
                credits[v] <= `NOC_CREDIT_W'(`NOC_CREDITS);
            else if (credit_in[v] && !spend[v])
                credits[v] <= credits[v] + 1'b1;
            else if (!credit_in[v] && spend[v])
                credits[v] <= credits[v] - 1'b1;
        end
    end

    always_comb
    begin
        flit         = '0;
        flit.head    = idx == 4'd0;
        flit.tail    = last;
        flit.vc      = pkt.vc;
        flit.measure = pkt.measure;
        if (idx == 4'd0)
        begin
            flit.payload.head.inj_time   = pkt.inj_time;
            flit.payload.head.dest       = pkt.dest;
            flit.payload.head.src        = pkt.src;
            flit.payload.head.flit_count = flit_count;
        end
        else
        begin
            flit.payload.body.src  = pkt.src;
            flit.payload.body.dest = pkt.dest;
            flit.payload.body.seq  = 8'(idx);
        end
    end

    for (genvar v = 0; v < `NOC_NVCS; v++)
    begin : g_credit_check
        // downstream never returns more than it was given
        credit_no_overflow: assert property (@(posedge clock) disable iff (reset)
            credit_in[v] && !spend[v] |-> credits[v] < `NOC_CREDIT_W'(`NOC_CREDITS));

        // an empty channel stays silent until a credit comes back
        silent_when_empty: assert property (@(posedge clock) disable iff (reset)
            credits[v] == '0 && !credit_in[v] |=> !spend[v]);
    end

endmodule

// File: rtl/flit_output_stage.sv
`timescale 1ns/10ps
`include "noc_consts.svh"

module flit_output_stage (
    input  logic                   clock,
    input  logic                   reset,
    input  noc_pkg::flit_t         flit,
    input  logic                   flit_valid,
    input  logic                   upstream_busy,
    output logic [`NOC_FLIT_W-1:0] flit_out,
    output logic [`NOC_NVCS-1:0]   flit_out_valid,
    output logic [15:0]            measured_flits,
    output logic                   is_quiescent
);

    noc_pkg::flit_t flit_q;

    always_ff @(posedge clock)
    begin
        if (flit_valid)
            flit_q <= flit;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            flit_out_valid <= '0;
            measured_flits <= 16'd0;
        end
        else
        begin
            // one-cycle pulse on the flit's own channel
            flit_out_valid <= flit_valid ? (`NOC_NVCS'(1) << flit.vc) : '0;
            if (flit_valid && flit.measure)
                measured_flits <= measured_flits + 16'd1;
        end
    end

    assign flit_out = flit_q;

    // nothing held upstream and nothing leaving this cycle
    assign is_quiescent = !upstream_busy && flit_out_valid == '0;

endmodule

// File: rtl/packet_player.sv
`timescale 1ns/10ps
`include "noc_consts.svh"

module packet_player #(
    parameter logic [7:0] node_addr = 8'h1B
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enable,
    input  logic [9:0]             sim_time,
    input  logic [`NOC_DESC_W-1:0] packet_in,
    input  logic                   packet_in_valid,
    output logic                   packet_request,
    output logic [`NOC_FLIT_W-1:0] flit_out,
    output logic [`NOC_NVCS-1:0]   flit_out_valid,
    input  logic [`NOC_NVCS-1:0]   credit_in,
    output logic [15:0]            measured_flits,
    output logic                   error,
    output logic                   is_quiescent
);

    packet_if       pif ();
    noc_pkg::flit_t gen_flit;
    logic           gen_flit_valid;
    logic           dec_busy;
    logic           gen_busy;

    descriptor_decoder #(
        .node_addr(node_addr)
    ) u_decoder (
        .clock          (clock),
        .reset          (reset),
        .enable         (enable),
        .packet_in      (packet_in),
        .packet_in_valid(packet_in_valid),
        .packet_request (packet_request),
        .error          (error),
        .busy           (dec_busy),
        .desc           (pif.source)
    );

    flit_generator u_generator (
        .clock     (clock),
        .reset     (reset),
        .enable    (enable),
        .sim_time  (sim_time),
        .desc      (pif.sink),
        .credit_in (credit_in),
        .flit      (gen_flit),
        .flit_valid(gen_flit_valid),
        .busy      (gen_busy)
    );

    // quiescent only once both upstream stages are empty
    flit_output_stage u_output (
        .clock         (clock),
        .reset         (reset),
        .flit          (gen_flit),
        .flit_valid    (gen_flit_valid),
        .upstream_busy (dec_busy | gen_busy),
        .flit_out      (flit_out),
        .flit_out_valid(flit_out_valid),
        .measured_flits(measured_flits),
        .is_quiescent  (is_quiescent)
    );

endmodule

// File: verif/packet_player_tb.sv
`timescale 1ns/10ps

module packet_player_tb;

    localparam int MAX_LINES = 32;
    localparam logic [7:0] NODE_ADDR = 8'h1B;

    logic        clock;
    logic        reset;
    logic        enable;
    logic [9:0]  sim_time;
    logic [31:0] packet_in;
    logic        packet_in_valid;
    logic        packet_request;
    logic [35:0] flit_out;
    logic [1:0]  flit_out_valid;
    logic [1:0]  credit_in;
    logic [15:0] measured_flits;
    logic        error;
    logic        is_quiescent;

    logic [15:0] test_mem [0:MAX_LINES*7-1];
    logic [35:0] expect_q [2][$];
    int          credit_due [2][$];
    int          outstanding [2];
    int          n_lines = 0;
    int          cycle = 0;
    int          hold_cnt = 0;
    int          checks = 0;
    int          errors = 0;
    int          expected_measured = 0;
    logic        err_expect = 1'b0;
    logic [31:0] lfsr = 32'h8c9c2ad2;

    packet_player #(
        .node_addr(NODE_ADDR)
    ) uut (
        .clock          (clock),
        .reset          (reset),
        .enable         (enable),
        .sim_time       (sim_time),
        .packet_in      (packet_in),
        .packet_in_valid(packet_in_valid),
        .packet_request (packet_request),
        .flit_out       (flit_out),
        .flit_out_valid (flit_out_valid),
        .credit_in      (credit_in),
        .measured_flits (measured_flits),
        .error          (error),
        .is_quiescent   (is_quiescent)
    );

    always #4 clock = ~clock;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // credit return delay of 1 to 8 cycles, three bits drawn
    task automatic draw_delay(output int d);
        d = 0;
        for (int b = 0; b < 3; b++)
        begin
            lfsr = lfsr_next(lfsr);
            d = (d << 1) | int'(lfsr[0]);
        end
        d = d + 1;
    endtask

    task automatic check_value(input string name, input logic [35:0] got,
                               input logic [35:0] want);
        checks++;
        assert (got === want)
        else
        begin
            errors++;
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, want, got);
        end
    endtask

    // one clock: sample outputs, score flits, then drive credits and time
    task automatic step();
        logic [35:0] exp;
        int          due;
        @(posedge clock);
        #1;
        cycle++;
        check_value("error", error, err_expect);
        for (int v = 0; v < 2; v++)
        begin
            if (flit_out_valid[v])
            begin
                checks++;
                assert (expect_q[v].size() != 0)
                else
                begin
                    errors++;
                    $display("%0t: flit on channel %0d while no packet was pending", $time, v);
                end
                if (expect_q[v].size() != 0)
                begin
                    exp = expect_q[v].pop_front();
                    check_value("flit_out", flit_out, exp);
                end
                if (flit_out[35])
                begin
                    checks++;
                    assert (flit_out[31:22] <= sim_time)
                    else
                    begin
                        errors++;
                        $display("[ERROR] %0t sim_time: expected at least %h, got %h",
                                 $time, flit_out[31:22], sim_time);
                    end
                end
                outstanding[v]++;
                draw_delay(due);
                credit_due[v].push_back(cycle + due);
            end
            checks++;
            assert (outstanding[v] <= 4)
            else
            begin
                errors++;
                $display("%0t: channel %0d sent %0d flits beyond its credits",
                         $time, v, outstanding[v] - 4);
            end
        end
        credit_in = 2'b00;
        for (int v = 0; v < 2; v++)
        begin
            if (hold_cnt == 0 && credit_due[v].size() != 0 && credit_due[v][0] <= cycle)
            begin
                credit_in[v] = 1'b1;
                void'(credit_due[v].pop_front());
                outstanding[v]--;
            end
        end
        if (hold_cnt > 0)
            hold_cnt--;
        if (cycle % 4 == 0)
            sim_time = sim_time + 10'd1;
    endtask

    // drive one descriptor and queue the flits it should produce
    task automatic present(input int i);
        logic [15:0] f [7];
        logic [35:0] fl;
        int          n;
        for (int c = 0; c < 7; c++)
            f[c] = test_mem[i*7 + c];
        packet_in = {1'b0, f[0][0], f[1][9:0], f[2][0], f[3][2:0], f[4][7:0], f[5][7:0]};
        packet_in_valid = 1'b1;
        hold_cnt = int'(f[6]);
        if (f[5][7:0] != NODE_ADDR)
            err_expect = 1'b1;
        else
        begin
            n = 1 << f[3][2:0];
            for (int k = 0; k < n; k++)
            begin
                if (k == 0)
                    fl = {1'b1, n == 1, f[2][0], f[0][0], f[1][9:0], f[4][7:0], f[5][7:0],
                          4'(n), 2'b00};
                else
                    fl = {1'b0, k == n - 1, f[2][0], f[0][0], f[5][7:0], f[4][7:0],
                          8'(k), 8'h00};
                expect_q[f[2][0]].push_back(fl);
            end
            if (f[0][0])
                expected_measured += n;
        end
    endtask

    initial
    begin
        int line;
        clock = 1'b0;
        reset = 1'b1;
        enable = 1'b0;
        sim_time = 10'd0;
        packet_in = 32'd0;
        packet_in_valid = 1'b0;
        credit_in = 2'b00;
        outstanding[0] = 0;
        outstanding[1] = 0;
        for (int i = 0; i < MAX_LINES*7; i++)
            test_mem[i] = 16'hffff;
        $readmemh("verif/packet_player_tests.txt", test_mem);
        while (n_lines < MAX_LINES && test_mem[n_lines*7] != 16'hffff)
            n_lines++;
        checks++;
        assert (n_lines > 0)
        else
        begin
            errors++;
            $display("no descriptors could be read from the test file");
        end

        repeat (5)
        begin
            @(posedge clock);
            #1;
            check_value("packet_request", packet_request, 1'b0);
            check_value("flit_out_valid", flit_out_valid, 2'b00);
            check_value("error", error, 1'b0);
        end
        reset = 1'b0;
        enable = 1'b1;
        step();
        check_value("packet_request", packet_request, 1'b1);
        check_value("is_quiescent", is_quiescent, 1'b1);

        line = 0;
        while (line < n_lines)
        begin
            packet_in_valid = 1'b0;
            if (packet_request)
            begin
                present(line);
                line++;
            end
            step();
        end
        packet_in_valid = 1'b0;

        // drain until every expected flit is out
        while (expect_q[0].size() != 0 || expect_q[1].size() != 0)
            step();
        // last flit clears the output register one cycle later
        step();
        check_value("is_quiescent", is_quiescent, 1'b1);
        check_value("measured_flits", measured_flits, 36'(expected_measured));

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        wait (n_lines > 0);
        repeat (n_lines * 200 + 1000) @(posedge clock);
        $display("timeout, the node did not drain within %0d cycles", n_lines * 200 + 1000);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Test failed");
        $finish;
    end

endmodule

// File: verif/packet_player_tests.txt
// columns, all hex: measure inj_time vc log_size dest src hold
// hold is the number of cycles that credits are withheld after the descriptor
1 000 0 0 22 1B 0
0 000 1 3 05 1B 0
1 004 0 2 3C 1B 0
0 006 1 1 41 1B 0
1 010 0 3 7E 1B 14
0 000 1 2 10 2C 0
1 012 1 3 09 1B 0
0 020 0 1 55 1B 0
1 030 1 0 66 1B 20
0 030 0 3 12 1B 0
1 040 0 2 23 1B 0
0 000 0 0 34 40 0
1 048 1 2 45 1B 0
0 050 0 3 56 1B 10
1 058 1 1 67 1B 0
0 060 0 0 78 1B 0

// File: vlog.f
+incdir+rtl
rtl/noc_pkg.sv
rtl/packet_if.sv
rtl/descriptor_decoder.sv
rtl/flit_generator.sv
rtl/flit_output_stage.sv
rtl/packet_player.sv
verif/packet_player_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = packet_player_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q "Test failed" $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
